//--- logic/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// Cache geometry
`define DC_INDEX_WIDTH        4    // 16 lines
`define DC_WORD_OFFSET_WIDTH  3    // 8 words per line
`define DC_BUS_ADDR_WIDTH     20   // Byte address of memory

// Derived from the above
`define DC_LINES              (1 << `DC_INDEX_WIDTH)
`define DC_QWORD_SEL_WIDTH    (`DC_WORD_OFFSET_WIDTH - 2)
`define DC_QWORDS_PER_LINE    (1 << `DC_QWORD_SEL_WIDTH)
`define DC_WORD_ADDR_WIDTH    (`DC_BUS_ADDR_WIDTH - 2)
`define DC_QWORD_ADDR_WIDTH   (`DC_BUS_ADDR_WIDTH - 4)

// Tag is whatever is left above index and word offset
`define DC_TAG_WIDTH \
   (`DC_WORD_ADDR_WIDTH - `DC_INDEX_WIDTH - `DC_WORD_OFFSET_WIDTH)

`endif

//--- logic/dcache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

   // Data widths
   typedef logic [31:0]  word_t;
   typedef logic [127:0] qword_t;    // One bus beat
   typedef logic [3:0]   byte_en_t;

   // Processor word address, split as {tag, index, word select}
   typedef logic [`DC_WORD_ADDR_WIDTH-1:0] word_addr_t;

   typedef logic [`DC_TAG_WIDTH-1:0]         tag_t;
   typedef logic [`DC_INDEX_WIDTH-1:0]       index_t;
   typedef logic [`DC_WORD_OFFSET_WIDTH-1:0] word_sel_t;

   // Upper bits of the word select
   typedef logic [`DC_QWORD_SEL_WIDTH-1:0] qword_sel_t;

   // Bus address counts qwords: {tag, index, qword select}
   typedef logic [`DC_QWORD_ADDR_WIDTH-1:0] qword_addr_t;

   // Dirty mask of one line, a bit per qword
   typedef logic [`DC_QWORDS_PER_LINE-1:0] dirty_t;

endpackage

`default_nettype wire

//--- logic/dcache_tag_array.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_tag_array (
   input  wire                     clk_i,
   input  wire                     rst_i,

   // Lookup of the current access
   input  wire dcache_pkg::index_t index_i,
   input  wire dcache_pkg::tag_t   tag_i,
   output logic                    hit_o,
   output dcache_pkg::tag_t        victim_tag_o,
   output logic                    victim_valid_o,

   // New tag from the refill controller
   input  wire                     fill_i,
   input  wire dcache_pkg::index_t fill_index_i,
   input  wire dcache_pkg::tag_t   fill_tag_i
);

   import dcache_pkg::*;

   tag_t                 tags_q [`DC_LINES];
   logic [`DC_LINES-1:0] valid_q;

   // Tag written when a refill starts
   always_ff @(posedge clk_i) begin
      if (fill_i) begin
         tags_q[fill_index_i] <= fill_tag_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         valid_q <= '0;   // All lines invalid
      end else if (fill_i) begin
         valid_q[fill_index_i] <= 1'b1;
      end
   end

   // Current contents of the indexed line and the victim on a miss
   assign victim_tag_o   = tags_q[index_i];
   assign victim_valid_o = valid_q[index_i];

   assign hit_o = victim_valid_o && (victim_tag_o == tag_i);

endmodule

`default_nettype wire

//--- logic/dcache_line_store.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_line_store (
   input  wire                         clk_i,
   input  wire                         rst_i,

   // Processor side, one word
   input  wire dcache_pkg::index_t     index_i,
   input  wire dcache_pkg::word_sel_t  word_sel_i,
   input  wire dcache_pkg::byte_en_t   we_i,       // Already gated on acceptance
   input  wire dcache_pkg::word_t      data_i,
   output dcache_pkg::word_t           rd_word_o,

   // Refill side, one qword
   input  wire dcache_pkg::index_t     fill_index_i,
   input  wire dcache_pkg::qword_sel_t fill_qsel_i,
   input  wire                         fill_we_i,
   input  wire dcache_pkg::qword_t     fill_data_i,
   output dcache_pkg::qword_t          fill_qword_o,
   output dcache_pkg::dirty_t          dirty_o
);

   import dcache_pkg::*;

   localparam int SLOTS = `DC_LINES * `DC_QWORDS_PER_LINE;

   // Qword slot address is {index, qword select}
   typedef logic [`DC_INDEX_WIDTH+`DC_QWORD_SEL_WIDTH-1:0] slot_t;

   qword_t     mem_q   [SLOTS];
   dirty_t     dirty_q [`DC_LINES];

   qword_sel_t cpu_qsel;
   logic [1:0] cpu_lane;   // Word within the qword
   slot_t      cpu_slot;
   slot_t      fill_slot;
   qword_t     cpu_qword;

   assign cpu_qsel  = word_sel_i[`DC_WORD_OFFSET_WIDTH-1:2];
   assign cpu_lane  = word_sel_i[1:0];
   assign cpu_slot  = {index_i, cpu_qsel};
   assign fill_slot = {fill_index_i, fill_qsel_i};

   // Byte writes from the processor, whole qwords from the bus.
   // The two never meet in one cycle since the processor is stalled
   // for the whole refill.
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < 4; b++) begin
         if (we_i[b]) begin
            mem_q[cpu_slot][cpu_lane * 32 + b * 8 +: 8] <= data_i[b * 8 +: 8];
         end
      end
      if (fill_we_i) begin
         mem_q[fill_slot] <= fill_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < `DC_LINES; i++) begin
            dirty_q[i] <= '0;
         end
      end else begin
         if (|we_i) begin
            dirty_q[index_i][cpu_qsel] <= 1'b1;   // Touched by a store
         end
         if (fill_we_i) begin
            dirty_q[fill_index_i][fill_qsel_i] <= 1'b0;   // Fresh from memory
         end
      end
   end

   // Read word for the processor
   assign cpu_qword = mem_q[cpu_slot];
   assign rd_word_o = cpu_qword[cpu_lane * 32 +: 32];

   // Victim data and dirty mask for the controller
   assign fill_qword_o = mem_q[fill_slot];
   assign dirty_o      = dirty_q[fill_index_i];

endmodule

`default_nettype wire

//--- logic/dcache_refill_ctrl.sv
`default_nettype none

`include "dcache_config.svh"

module dcache_refill_ctrl (
   input  wire                          clk_i,
   input  wire                          rst_i,

   // Access and lookup result
   input  wire                          req_i,
   input  wire                          hit_i,
   input  wire dcache_pkg::index_t      index_i,
   input  wire dcache_pkg::tag_t        tag_i,
   input  wire dcache_pkg::tag_t        victim_tag_i,
   input  wire                          victim_valid_i,

   // Line store readback
   input  wire dcache_pkg::dirty_t      dirty_i,
   input  wire dcache_pkg::qword_t      victim_qword_i,

   output logic                         busy_o,
   output logic                         fill_tag_we_o,
   output dcache_pkg::index_t           fill_index_o,
   output dcache_pkg::qword_sel_t       fill_qsel_o,
   output logic                         fill_we_o,

   // Memory bus
   output dcache_pkg::qword_addr_t      bus_addr_o,
   output logic                         bus_we_o,
   output dcache_pkg::qword_t           bus_data_o,
   output logic                         bus_valid_o,
   input  wire                          bus_valid_i
);

   import dcache_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WRITE_BACK,
      ST_READ,
      ST_NEXT
   } state_e;

   state_e     state_q;
   qword_sel_t qsel_q;
   logic       bus_valid_q;

   // Captured at the start of a refill
   index_t     index_q;
   tag_t       new_tag_q;
   tag_t       old_tag_q;
   logic       old_valid_q;

   logic       start;
   logic       ack;
   logic       last_qword;

   assign start      = (state_q == ST_IDLE) && req_i && !hit_i;
   assign ack        = bus_valid_q && bus_valid_i;   // Ignore stray acknowledges
   assign last_qword = (qsel_q == qword_sel_t'(`DC_QWORDS_PER_LINE - 1));

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         qsel_q      <= '0;
         bus_valid_q <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (start) begin
                  qsel_q  <= '0;
                  state_q <= ST_NEXT;
               end
            end
            ST_NEXT: begin
               // Old data goes out before new data comes in
               bus_valid_q <= 1'b1;
               if (old_valid_q && dirty_i[qsel_q]) begin
                  state_q <= ST_WRITE_BACK;
               end else begin
                  state_q <= ST_READ;
               end
            end
            ST_WRITE_BACK: begin
               if (ack) begin
                  bus_valid_q <= 1'b0;   // One idle cycle before the read
                  state_q     <= ST_READ;
               end else begin
                  bus_valid_q <= 1'b1;
               end
            end
            ST_READ: begin
               if (ack) begin
                  bus_valid_q <= 1'b0;
                  if (last_qword) begin
                     state_q <= ST_IDLE;
                  end else begin
                     qsel_q  <= qsel_q + 1'b1;
                     state_q <= ST_NEXT;
                  end
               end else begin
                  bus_valid_q <= 1'b1;   // Raise after the write-back gap
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         index_q     <= index_i;
         new_tag_q   <= tag_i;
         old_tag_q   <= victim_tag_i;
         old_valid_q <= victim_valid_i;
      end
   end

   assign busy_o        = (state_q != ST_IDLE);
   assign fill_tag_we_o = start;   // New tag goes in right away

   // Lookup line while idle, refill line otherwise
   assign fill_index_o = (state_q == ST_IDLE) ? index_i : index_q;
   assign fill_qsel_o  = qsel_q;
   assign fill_we_o    = (state_q == ST_READ) && ack;

   assign bus_we_o    = (state_q == ST_WRITE_BACK);
   assign bus_addr_o  = {bus_we_o ? old_tag_q : new_tag_q, index_q, qsel_q};
   assign bus_data_o  = victim_qword_i;
   assign bus_valid_o = bus_valid_q;

endmodule

`default_nettype wire

//--- logic/data_cache.sv
`default_nettype none

module data_cache (
   input  wire                          clk_i,
   input  wire                          rst_i,

   // Processor load/store port
   input  wire                          en_i,
   input  wire dcache_pkg::word_addr_t  addr_i,
   input  wire dcache_pkg::byte_en_t    we_i,
   input  wire dcache_pkg::word_t       data_i,
   output dcache_pkg::word_t            data_o,
   output logic                         stall_o,

   // Memory bus
   output dcache_pkg::qword_addr_t      bus_addr_o,
   output logic                         bus_we_o,
   output dcache_pkg::qword_t           bus_data_o,
   output logic                         bus_valid_o,
   input  wire dcache_pkg::qword_t      bus_data_i,
   input  wire                          bus_valid_i
);

   import dcache_pkg::*;

   tag_t       acc_tag;
   index_t     acc_index;
   word_sel_t  acc_word_sel;

   logic       hit;
   logic       busy;
   logic       accept;
   byte_en_t   store_we;
   word_t      rd_word;

   tag_t       victim_tag;
   logic       victim_valid;
   logic       fill_tag_we;
   index_t     fill_index;
   qword_sel_t fill_qsel;
   logic       fill_we;
   qword_t     fill_qword;
   dirty_t     dirty;

   assign {acc_tag, acc_index, acc_word_sel} = addr_i;

   // Hold the processor on a miss and for the whole refill
   assign stall_o  = en_i && (!hit || busy);
   assign accept   = en_i && !stall_o;
   assign store_we = accept ? we_i : '0;

   // Read data stays until the next accepted read
   always_ff @(posedge clk_i) begin
      if (accept && (we_i == '0)) begin
         data_o <= rd_word;
      end
   end

   dcache_tag_array u_tag_array (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .index_i        (acc_index),
      .tag_i          (acc_tag),
      .hit_o          (hit),
      .victim_tag_o   (victim_tag),
      .victim_valid_o (victim_valid),
      .fill_i         (fill_tag_we),
      .fill_index_i   (fill_index),
      .fill_tag_i     (acc_tag)       // Written in the cycle of the miss
   );

   dcache_line_store u_line_store (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .index_i      (acc_index),
      .word_sel_i   (acc_word_sel),
      .we_i         (store_we),
      .data_i       (data_i),
      .rd_word_o    (rd_word),
      .fill_index_i (fill_index),
      .fill_qsel_i  (fill_qsel),
      .fill_we_i    (fill_we),
      .fill_data_i  (bus_data_i),
      .fill_qword_o (fill_qword),
      .dirty_o      (dirty)
   );

   dcache_refill_ctrl u_refill_ctrl (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .req_i          (en_i),
      .hit_i          (hit),
      .index_i        (acc_index),
      .tag_i          (acc_tag),
      .victim_tag_i   (victim_tag),
      .victim_valid_i (victim_valid),
      .dirty_i        (dirty),
      .victim_qword_i (fill_qword),
      .busy_o         (busy),
      .fill_tag_we_o  (fill_tag_we),
      .fill_index_o   (fill_index),
      .fill_qsel_o    (fill_qsel),
      .fill_we_o      (fill_we),
      .bus_addr_o     (bus_addr_o),
      .bus_we_o       (bus_we_o),
      .bus_data_o     (bus_data_o),
      .bus_valid_o    (bus_valid_o),
      .bus_valid_i    (bus_valid_i)
   );

endmodule

`default_nettype wire

//--- tb/tb_bus_memory.sv
`default_nettype none

`include "dcache_config.svh"

module tb_bus_memory (
   input  wire                          clk_i,
   input  wire                          rst_i,
   input  wire dcache_pkg::qword_addr_t bus_addr_i,
   input  wire                          bus_we_i,
   input  wire dcache_pkg::qword_t      bus_data_i,
   input  wire                          bus_valid_i,
   output dcache_pkg::qword_t           bus_data_o,
   output logic                         bus_valid_o
);

   timeunit 1ns;
   timeprecision 1ps;

   import dcache_pkg::*;

   localparam int          DEPTH = 1 << `DC_QWORD_ADDR_WIDTH;
   localparam logic [31:0] SEED  = 32'haa0b_0f46;

   qword_t mem_q [DEPTH];

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   initial begin : serve
      logic [31:0] rng;
      int          delay;
      logic        pending;
      logic        respond;
      qword_addr_t req_addr;
      logic        req_we;
      qword_t      req_data;
      rng         = SEED;
      delay       = 0;
      pending     = 1'b0;
      bus_valid_o = 1'b0;
      bus_data_o  = '0;
      // Qword q holds four consecutive draws, lane 0 first
      for (int q = 0; q < DEPTH; q++) begin
         for (int l = 0; l < 4; l++) begin
            rng = xorshift32(rng);
            mem_q[q][l * 32 +: 32] = rng;
         end
      end
      forever begin
         @(negedge clk_i);   // Request side is settled here
         respond = 1'b0;
         if (rst_i) begin
            pending = 1'b0;
         end else if (bus_valid_i && !bus_valid_o) begin
            if (!pending) begin
               rng     = xorshift32(rng);
               delay   = int'(rng % 6);   // Back-pressure of 0 to 5 cycles
               pending = 1'b1;
            end
            if (delay == 0) begin
               respond  = 1'b1;
               pending  = 1'b0;
               req_addr = bus_addr_i;
               req_we   = bus_we_i;
               req_data = bus_data_i;
            end else begin
               delay--;
            end
         end
         @(posedge clk_i);
         if (respond) begin
            if (req_we) begin
               mem_q[req_addr] = req_data;
            end
            bus_data_o <= mem_q[req_addr];
         end
         bus_valid_o <= respond;   // Acknowledge lasts one cycle
      end
   end

endmodule

`default_nettype wire

//--- tb/tb_data_cache.sv
`default_nettype none

`include "dcache_config.svh"

module tb_data_cache;

   timeunit 1ns;
   timeprecision 1ps;

   import dcache_pkg::*;

   localparam int          WORDS   = 1 << `DC_WORD_ADDR_WIDTH;
   localparam int          TIMEOUT = 200;   // Cycles, far above one full refill
   localparam logic [31:0] SEED    = 32'haa0b_0f46;

   logic        clk;
   logic        rst;
   logic        en;
   word_addr_t  addr;
   byte_en_t    we;
   word_t       wdata;
   word_t       rdata;
   logic        stall;
   qword_addr_t bus_addr;
   logic        bus_we;
   qword_t      bus_wdata;
   logic        bus_req;
   qword_t      bus_rdata;
   logic        bus_ack;

   word_t       ref_mem [WORDS];   // Memory as the processor sees it
   logic [31:0] rng;

   data_cache dut (
      .clk_i       (clk),
      .rst_i       (rst),
      .en_i        (en),
      .addr_i      (addr),
      .we_i        (we),
      .data_i      (wdata),
      .data_o      (rdata),
      .stall_o     (stall),
      .bus_addr_o  (bus_addr),
      .bus_we_o    (bus_we),
      .bus_data_o  (bus_wdata),
      .bus_valid_o (bus_req),
      .bus_data_i  (bus_rdata),
      .bus_valid_i (bus_ack)
   );

   tb_bus_memory mem_model (
      .clk_i       (clk),
      .rst_i       (rst),
      .bus_addr_i  (bus_addr),
      .bus_we_i    (bus_we),
      .bus_data_i  (bus_wdata),
      .bus_valid_i (bus_req),
      .bus_data_o  (bus_rdata),
      .bus_valid_o (bus_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_addr_t make_addr(input tag_t t, input index_t i, input word_sel_t s);
      return {t, i, s};
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t d, input byte_en_t be);
      word_t w;
      w = old;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            w[b * 8 +: 8] = d[b * 8 +: 8];
         end
      end
      return w;
   endfunction

   // Lane 0 sits in the low word of the qword
   function automatic qword_t expected_qword(input qword_addr_t qa);
      return {ref_mem[{qa, 2'd3}], ref_mem[{qa, 2'd2}],
              ref_mem[{qa, 2'd1}], ref_mem[{qa, 2'd0}]};
   endfunction

   task automatic end_with_failure();
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic compare_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_qword(input string name, input qword_t got, input qword_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         end_with_failure();
      end
   endtask

   task automatic fill_reference();
      logic [31:0] x;
      x = SEED;
      for (int w = 0; w < WORDS; w++) begin
         x          = xorshift32(x);
         ref_mem[w] = x;   // Same order as the memory model fill
      end
      rng = x;
   endtask

   // Presents one access and returns once it is accepted
   task automatic access(input word_addr_t a, input byte_en_t be, input word_t d,
                         output int stalls);
      int cycles;
      cycles = 0;
      @(posedge clk);
      en    <= 1'b1;
      addr  <= a;
      we    <= be;
      wdata <= d;
      @(negedge clk);
      while (stall) begin
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout: stall_o stayed high for address %h", a);
            end_with_failure();
         end
         @(negedge clk);
      end
      @(posedge clk);   // Accepted at this edge
      en     <= 1'b0;
      we     <= '0;
      stalls = cycles;
   endtask

   task automatic read_check(input word_addr_t a, output int stalls);
      access(a, '0, '0, stalls);
      @(negedge clk);
      compare_word($sformatf("data_o at %h", a), rdata, ref_mem[a]);
   endtask

   task automatic write_word(input word_addr_t a, input byte_en_t be, input word_t d,
                             output int stalls);
      access(a, be, d, stalls);
      ref_mem[a] = merge_bytes(ref_mem[a], d, be);
   endtask

   task automatic test_reset_state();
      int stalls;
      @(negedge clk);
      compare_flag("stall_o", stall, 1'b0);
      compare_flag("bus_valid_o", bus_req, 1'b0);
      read_check(make_addr(11'h005, 4'h3, 3'd0), stalls);
      if (stalls == 0) begin
         $display("First read of a line was served without a stall");
         end_with_failure();
      end
   endtask

   task automatic test_read_hits();
      int stalls;
      read_check(make_addr(11'h007, 4'h5, 3'd2), stalls);
      for (int s = 0; s < 8; s++) begin
         read_check(make_addr(11'h007, 4'h5, word_sel_t'(s)), stalls);
         if (stalls != 0) begin
            $display("Read of cached word %0d stalled for %0d cycles", s, stalls);
            end_with_failure();
         end
      end
   endtask

   task automatic test_byte_writes();
      word_addr_t a;
      word_addr_t b;
      int         stalls;
      a = make_addr(11'h007, 4'h5, 3'd3);
      b = make_addr(11'h007, 4'h5, 3'd4);
      write_word(a, 4'b0101, 32'ha1b2_c3d4, stalls);
      write_word(a, 4'b1000, 32'h5e00_0000, stalls);
      write_word(b, 4'b0110, 32'h0077_8800, stalls);
      read_check(a, stalls);
      read_check(b, stalls);
   endtask

   task automatic test_eviction();
      word_addr_t  line_a;
      word_addr_t  line_b;
      qword_addr_t qa;
      int          stalls;
      line_a = make_addr(11'h009, 4'h6, 3'd5);
      line_b = make_addr(11'h00a, 4'h6, 3'd0);
      qa     = qword_addr_t'(line_a >> 2);
      read_check(line_a, stalls);
      write_word(line_a, 4'hf, 32'hcafe_f00d, stalls);
      read_check(line_b, stalls);   // Same index, line A goes back to memory
      compare_qword($sformatf("memory qword %h", qa), mem_model.mem_q[qa], expected_qword(qa));
      read_check(line_a, stalls);
   endtask

   task automatic test_random_sweep();
      word_addr_t a;
      byte_en_t   be;
      int         stalls;
      int         writes;
      writes = 0;
      for (int n = 0; n < 200; n++) begin
         rng = xorshift32(rng);
         // Four tags over eight lines, so evictions are frequent
         a  = make_addr(11'h010 + tag_t'(rng[1:0]), index_t'(rng[4:2]), word_sel_t'(rng[7:5]));
         be = rng[11:8];
         if (rng[12] && (be != '0)) begin
            rng = xorshift32(rng);
            write_word(a, be, rng, stalls);
            writes++;
         end else begin
            read_check(a, stalls);
         end
      end
      $display("Random sweep done, %0d writes and %0d reads", writes, 200 - writes);
   endtask

   initial begin
      rst   = 1'b1;
      en    = 1'b0;
      addr  = '0;
      we    = '0;
      wdata = '0;
      fill_reference();
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      test_reset_state();
      test_read_hits();
      test_byte_writes();
      test_eviction();
      test_random_sweep();
      $display("All tests passed!");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_line_store.sv
logic/dcache_refill_ctrl.sv
logic/data_cache.sv
tb/tb_bus_memory.sv
tb/tb_data_cache.sv

//--- Makefile
# Verilator build and run of the data cache testbench

TOP := tb_data_cache

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
		-f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
